/* tb/decode_unit_testdata.txt */
// columns: instruction word, expected control word (37 bits)
// entry 0 is the latency case, entries 1..6 the back-pressure case
003100b3 0422184000
403100b3 0422188000
003110b3 04221a0000
003130b3 042219c000
403150b3 04221a8000
003170b3 042218c000
023100b3 04221ac000
023150b3 04221b0000
023170b3 04221b4000
003100bb 0422184001
403100bb 0422188001
023100bb 04221ac001
023140bb 04221b8001
023160bb 04221bc001
00510093 0422005200
fff12093 0422019200
0ff17093 042200d200
00311093 0422021c00
02115093 0422025c00
40315093 0422029c00
0051009b 0422005201
0031109b 0422021c01
4031509b 0422029c01
00810083 0422005220
00811083 0422005224
00812083 0422005228
00813083 042200522c
00814083 0422005222
00815083 0422005226
00816083 042200522a
00310423 0002185410
00311423 0002185414
00312423 0002185418
00313423 000218541c
00310463 00021c0700
00311463 00021c4700
00314463 00021c8700
00315463 00021cc700
00316463 00021d0700
00317463 00021d4700
000000ef 0420006a80
000100e7 04220062c0
123450b7 0420005800
00001097 0420007800
00100073 0800000000
00000073 1000000000
ffffffff 1000000000
023160b3 1000000000
00817083 1000000000
40311093 1000000000
0011609b 1000000000

/* filelist.f */
rtl/rv_ctrl_pkg.sv
rtl/opcode_decoder.sv
rtl/inst_intake.sv
rtl/ctrl_fifo.sv
rtl/ctrl_issue.sv
rtl/decode_unit.sv
tb/decode_unit_asserts.sv
tb/decode_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module decode_unit_tb \
    -f filelist.f -o sim_decode_unit
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_decode_unit
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

/* tb/decode_unit_tb.sv */
`timescale 1ns/1ps

module decode_unit_tb;

    logic                    clk;
    logic                    arst_n;
    rv_ctrl_pkg::inst_t      inst;
    logic                    in_req;
    logic                    in_ack;
    logic                    out_req;
    logic                    out_ack;
    logic                    illegal;
    logic                    ebreak;
    logic                    reg_wen;
    rv_ctrl_pkg::reg_addr_t  rd;
    rv_ctrl_pkg::reg_addr_t  rs1;
    rv_ctrl_pkg::reg_addr_t  rs2;
    rv_ctrl_pkg::alu_op_e    alu_op;
    rv_ctrl_pkg::alu_src_e   alu_src;
    rv_ctrl_pkg::imm_kind_e  imm_kind;
    logic                    branch;
    logic                    jump;
    logic                    jalr;
    logic                    mem_read;
    logic                    mem_write;
    rv_ctrl_pkg::mem_size_t  mem_size;
    logic                    mem_unsigned;
    logic                    word_op;
    rv_ctrl_pkg::ctrl_word_t got_word;

    logic [63:0] table_mem [128];  // instruction then expected word per entry
    int          num_entries;
    logic        loaded;
    logic [15:0] lfsr;

    decode_unit decode_unit_i (.*);

    bind decode_unit decode_unit_asserts asserts_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .in_req  (in_req),
        .in_ack  (in_ack),
        .out_req (out_req),
        .out_ack (out_ack),
        .push    (push),
        .full    (full),
        .fields  ({illegal, ebreak, reg_wen, rd, rs1, rs2, alu_op, alu_src, imm_kind,
                   branch, jump, jalr, mem_read, mem_write, mem_size, mem_unsigned, word_op})
    );

    always_comb begin
        got_word = '0;
        got_word[rv_ctrl_pkg::OFS_ILLEGAL]       = illegal;
        got_word[rv_ctrl_pkg::OFS_EBREAK]        = ebreak;
        got_word[rv_ctrl_pkg::OFS_REG_WEN]       = reg_wen;
        got_word[rv_ctrl_pkg::OFS_RD +: 5]       = rd;
        got_word[rv_ctrl_pkg::OFS_RS1 +: 5]      = rs1;
        got_word[rv_ctrl_pkg::OFS_RS2 +: 5]      = rs2;
        got_word[rv_ctrl_pkg::OFS_ALU_OP +: 5]   = alu_op;
        got_word[rv_ctrl_pkg::OFS_ALU_SRC +: 2]  = alu_src;
        got_word[rv_ctrl_pkg::OFS_IMM_KIND +: 3] = imm_kind;
        got_word[rv_ctrl_pkg::OFS_BRANCH]        = branch;
        got_word[rv_ctrl_pkg::OFS_JUMP]          = jump;
        got_word[rv_ctrl_pkg::OFS_JALR]          = jalr;
        got_word[rv_ctrl_pkg::OFS_MEM_READ]      = mem_read;
        got_word[rv_ctrl_pkg::OFS_MEM_WRITE]     = mem_write;
        got_word[rv_ctrl_pkg::OFS_MEM_SIZE +: 2] = mem_size;
        got_word[rv_ctrl_pkg::OFS_MEM_UNSIGNED]  = mem_unsigned;
        got_word[rv_ctrl_pkg::OFS_WORD_OP]       = word_op;
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic int random_gap();
        logic [2:0] g;
        for (int b = 0; b < 3; b++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            g[b] = lfsr[0];
        end
        return int'(g);
    endfunction

    task automatic expect_value(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
        assert (got == exp) else begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic send_inst(input int idx, input int gap);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        inst   <= table_mem[2*idx][31:0];
        in_req <= 1'b1;
        do @(posedge clk); while (!in_ack);
        in_req <= 1'b0;
        do @(posedge clk); while (in_ack);
    endtask

    task automatic receive_check(input int idx, input int gap);
        do @(posedge clk); while (!out_req);
        expect_value($sformatf("control word of entry %0d", idx), 64'(got_word),
                     table_mem[2*idx+1]);
        repeat (gap) @(posedge clk);
        out_ack <= 1'b1;
        do @(posedge clk); while (out_req);
        out_ack <= 1'b0;
    endtask

    initial begin
        int lat;
        arst_n  = 1'b0;
        in_req  = 1'b0;
        out_ack = 1'b0;
        inst    = '0;
        loaded  = 1'b0;
        lfsr    = 16'd47803;
        for (int i = 0; i < $size(table_mem); i++) begin
            table_mem[i] = {~32'(i), 32'(i)};  // upper half set marks an unloaded slot
        end
        $readmemh("tb/decode_unit_testdata.txt", table_mem);
        num_entries = 0;
        while (num_entries < $size(table_mem) / 2 &&
               table_mem[2*num_entries][63:32] == 32'd0) begin
            num_entries++;
        end
        assert (num_entries >= 7) else begin
            $display("Testdata file holds %0d entries but at least 7 are needed", num_entries);
            $display("Something failed");
            $fatal(1);
        end
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        repeat (5) begin
            @(posedge clk);
            expect_value("in_ack after reset", 64'(in_ack), 64'd0);
            expect_value("out_req after reset", 64'(out_req), 64'd0);
        end

        // idle unit with receiver answering at once
        fork
            send_inst(0, 0);
            receive_check(0, 0);
            begin
                do @(posedge clk); while (!in_req);
                lat = 0;
                while (!out_req) begin
                    @(posedge clk);
                    lat++;
                end
                expect_value("in_req to out_req latency", 64'(lat), 64'd3);
            end
        join

        // fill FIFO and issue stage with the receiver stalled
        for (int i = 1; i <= 5; i++) send_inst(i, random_gap());
        @(posedge clk);
        inst   <= table_mem[12][31:0];
        in_req <= 1'b1;
        repeat (20) begin
            @(posedge clk);
            expect_value("in_ack while FIFO full", 64'(in_ack), 64'd0);
        end
        fork
            begin
                do @(posedge clk); while (!in_ack);
                in_req <= 1'b0;
                do @(posedge clk); while (in_ack);
            end
            begin
                for (int i = 1; i <= 6; i++) receive_check(i, random_gap());
            end
        join

        fork
            begin
                for (int i = 7; i < num_entries; i++) send_inst(i, random_gap());
            end
            begin
                for (int i = 7; i < num_entries; i++) receive_check(i, random_gap());
            end
        join

        $display("Everything OK");
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (num_entries * 40 + 100) @(posedge clk);
        $display("Watchdog expired at %0t ns, the run hung", $time);
        $display("Something failed");
        $fatal(1);
    end

endmodule

/* tb/decode_unit_asserts.sv */
`timescale 1ns/1ps

module decode_unit_asserts (
    input logic                            clk,
    input logic                            arst_n,
    input logic                            in_req,
    input logic                            in_ack,
    input logic                            out_req,
    input logic                            out_ack,
    input logic                            push,
    input logic                            full,
    input logic [rv_ctrl_pkg::CTRL_W-1:0]  fields
);

    ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose without in_req");

    req_held: assert property (@(posedge clk) disable iff (!arst_n)
        out_req && !out_ack |=> out_req)
        else $error("out_req dropped before out_ack");

    fields_stable: assert property (@(posedge clk) disable iff (!arst_n)
        out_req |=> !out_req || $stable(fields))
        else $error("control fields changed while out_req high");

    no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        !(push && full))
        else $error("push while FIFO full");

endmodule

/* rtl/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit (
    input  logic                   clk,
    input  logic                   arst_n,
    input  rv_ctrl_pkg::inst_t     inst,
    input  logic                   in_req,
    output logic                   in_ack,
    output logic                   out_req,
    input  logic                   out_ack,
    output logic                   illegal,
    output logic                   ebreak,
    output logic                   reg_wen,
    output rv_ctrl_pkg::reg_addr_t rd,
    output rv_ctrl_pkg::reg_addr_t rs1,
    output rv_ctrl_pkg::reg_addr_t rs2,
    output rv_ctrl_pkg::alu_op_e   alu_op,
    output rv_ctrl_pkg::alu_src_e  alu_src,
    output rv_ctrl_pkg::imm_kind_e imm_kind,
    output logic                   branch,
    output logic                   jump,
    output logic                   jalr,
    output logic                   mem_read,
    output logic                   mem_write,
    output rv_ctrl_pkg::mem_size_t mem_size,
    output logic                   mem_unsigned,
    output logic                   word_op
);

    logic                    push;
    logic                    pop;
    logic                    full;
    logic                    empty;
    rv_ctrl_pkg::ctrl_word_t push_word;
    rv_ctrl_pkg::ctrl_word_t head_word;

    inst_intake intake_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .inst      (inst),
        .in_req    (in_req),
        .in_ack    (in_ack),
        .full      (full),
        .push      (push),
        .push_word (push_word)
    );

    ctrl_fifo fifo_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (push),
        .push_word (push_word),
        .full      (full),
        .pop       (pop),
        .empty     (empty),
        .head_word (head_word)
    );

    ctrl_issue issue_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .empty        (empty),
        .head_word    (head_word),
        .pop          (pop),
        .out_req      (out_req),
        .out_ack      (out_ack),
        .illegal      (illegal),
        .ebreak       (ebreak),
        .reg_wen      (reg_wen),
        .rd           (rd),
        .rs1          (rs1),
        .rs2          (rs2),
        .alu_op       (alu_op),
        .alu_src      (alu_src),
        .imm_kind     (imm_kind),
        .branch       (branch),
        .jump         (jump),
        .jalr         (jalr),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_size     (mem_size),
        .mem_unsigned (mem_unsigned),
        .word_op      (word_op)
    );

endmodule

/* rtl/ctrl_issue.sv */
`timescale 1ns/1ps

module ctrl_issue (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    empty,
    input  rv_ctrl_pkg::ctrl_word_t head_word,
    output logic                    pop,
    output logic                    out_req,
    input  logic                    out_ack,
    output logic                    illegal,
    output logic                    ebreak,
    output logic                    reg_wen,
    output rv_ctrl_pkg::reg_addr_t  rd,
    output rv_ctrl_pkg::reg_addr_t  rs1,
    output rv_ctrl_pkg::reg_addr_t  rs2,
    output rv_ctrl_pkg::alu_op_e    alu_op,
    output rv_ctrl_pkg::alu_src_e   alu_src,
    output rv_ctrl_pkg::imm_kind_e  imm_kind,
    output logic                    branch,
    output logic                    jump,
    output logic                    jalr,
    output logic                    mem_read,
    output logic                    mem_write,
    output rv_ctrl_pkg::mem_size_t  mem_size,
    output logic                    mem_unsigned,
    output logic                    word_op
);

    typedef enum logic [1:0] {
        st_idle,
        st_req_high,
        st_wait_release
    } state_e;

    state_e                  state;
    rv_ctrl_pkg::ctrl_word_t word_q;

    assign out_req = (state == st_req_high);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            pop   <= 1'b0;
        end else begin
            pop <= 1'b0;
            case (state)
                st_idle: begin
                    if (pop) begin
                        state <= st_req_high;  // word taken this edge
                    end else begin
                        pop <= !empty;
                    end
                end
                st_req_high:     if (out_ack) state <= st_wait_release;
                st_wait_release: if (!out_ack) state <= st_idle;
                default:         state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) word_q <= head_word;
    end

    assign illegal      = word_q[rv_ctrl_pkg::OFS_ILLEGAL];
    assign ebreak       = word_q[rv_ctrl_pkg::OFS_EBREAK];
    assign reg_wen      = word_q[rv_ctrl_pkg::OFS_REG_WEN];
    assign rd           = word_q[rv_ctrl_pkg::OFS_RD +: rv_ctrl_pkg::REG_W];
    assign rs1          = word_q[rv_ctrl_pkg::OFS_RS1 +: rv_ctrl_pkg::REG_W];
    assign rs2          = word_q[rv_ctrl_pkg::OFS_RS2 +: rv_ctrl_pkg::REG_W];
    assign alu_op       = rv_ctrl_pkg::alu_op_e'(
                              word_q[rv_ctrl_pkg::OFS_ALU_OP +: rv_ctrl_pkg::ALU_OP_W]);
    assign alu_src      = rv_ctrl_pkg::alu_src_e'(
                              word_q[rv_ctrl_pkg::OFS_ALU_SRC +: rv_ctrl_pkg::ALU_SRC_W]);
    assign imm_kind     = rv_ctrl_pkg::imm_kind_e'(
                              word_q[rv_ctrl_pkg::OFS_IMM_KIND +: rv_ctrl_pkg::IMM_KIND_W]);
    assign branch       = word_q[rv_ctrl_pkg::OFS_BRANCH];
    assign jump         = word_q[rv_ctrl_pkg::OFS_JUMP];
    assign jalr         = word_q[rv_ctrl_pkg::OFS_JALR];
    assign mem_read     = word_q[rv_ctrl_pkg::OFS_MEM_READ];
    assign mem_write    = word_q[rv_ctrl_pkg::OFS_MEM_WRITE];
    assign mem_size     = word_q[rv_ctrl_pkg::OFS_MEM_SIZE +: rv_ctrl_pkg::MEM_SIZE_W];
    assign mem_unsigned = word_q[rv_ctrl_pkg::OFS_MEM_UNSIGNED];
    assign word_op      = word_q[rv_ctrl_pkg::OFS_WORD_OP];

endmodule

/* rtl/ctrl_fifo.sv */
`timescale 1ns/1ps

module ctrl_fifo #(
    parameter int DEPTH = rv_ctrl_pkg::FIFO_DEPTH
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    push,
    input  rv_ctrl_pkg::ctrl_word_t push_word,
    output logic                    full,
    input  logic                    pop,
    output logic                    empty,
    output rv_ctrl_pkg::ctrl_word_t head_word
);

    rv_ctrl_pkg::ctrl_word_t  mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;
    logic                     do_push;
    logic                     do_pop;

    assign do_push   = push && !full;
    assign do_pop    = pop && !empty;
    assign full      = (count == ($clog2(DEPTH) + 1)'(DEPTH));
    assign empty     = (count == '0);
    assign head_word = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_word;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps since depth is a power of two
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* rtl/inst_intake.sv */
`timescale 1ns/1ps

module inst_intake (
    input  logic                    clk,
    input  logic                    arst_n,
    input  rv_ctrl_pkg::inst_t      inst,
    input  logic                    in_req,
    output logic                    in_ack,
    input  logic                    full,
    output logic                    push,
    output rv_ctrl_pkg::ctrl_word_t push_word
);

    typedef enum logic {
        st_idle,
        st_acked
    } state_e;

    state_e state;

    opcode_decoder decoder_i (
        .inst (inst),
        .ctrl (push_word)
    );

    assign push   = (state == st_idle) && in_req && !full;  // full holds off the ack
    assign in_ack = (state == st_acked);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:  if (push) state <= st_acked;
                st_acked: if (!in_req) state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

endmodule

/* rtl/opcode_decoder.sv */
`timescale 1ns/1ps

module opcode_decoder (
    input  rv_ctrl_pkg::inst_t      inst,
    output rv_ctrl_pkg::ctrl_word_t ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [6:0] shift_f7;
    logic       illegal, ebreak, reg_wen, use_rs1, use_rs2;
    logic       branch, jump, jalr, mem_read, mem_write, mem_unsigned, word_op;
    rv_ctrl_pkg::mem_size_t mem_size;
    rv_ctrl_pkg::alu_op_e   alu_op;
    rv_ctrl_pkg::alu_src_e  alu_src;
    rv_ctrl_pkg::imm_kind_e imm_kind;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    // rv64 shamt is 6 bits, so inst[25] belongs to it outside the word ops
    assign shift_f7 = (opcode == rv_ctrl_pkg::OPC_OP_IMM_32) ? funct7 : {inst[31:26], 1'b0};

    always_comb begin
        illegal      = 1'b0;
        ebreak       = 1'b0;
        reg_wen      = 1'b0;
        use_rs1      = 1'b0;
        use_rs2      = 1'b0;
        branch       = 1'b0;
        jump         = 1'b0;
        jalr         = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        mem_unsigned = 1'b0;
        word_op      = 1'b0;
        mem_size     = '0;
        alu_op       = rv_ctrl_pkg::alu_none;
        alu_src      = rv_ctrl_pkg::src_reg;
        imm_kind     = rv_ctrl_pkg::imm_none;
        case (opcode)
            rv_ctrl_pkg::OPC_OP: begin
                reg_wen = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case ({funct7, funct3})
                    {rv_ctrl_pkg::F7_BASE, 3'b000}:   alu_op = rv_ctrl_pkg::alu_add;
                    {rv_ctrl_pkg::F7_ALT, 3'b000}:    alu_op = rv_ctrl_pkg::alu_sub;
                    {rv_ctrl_pkg::F7_BASE, 3'b001}:   alu_op = rv_ctrl_pkg::alu_sll;
                    {rv_ctrl_pkg::F7_BASE, 3'b010}:   alu_op = rv_ctrl_pkg::alu_slt;
                    {rv_ctrl_pkg::F7_BASE, 3'b011}:   alu_op = rv_ctrl_pkg::alu_sltu;
                    {rv_ctrl_pkg::F7_BASE, 3'b100}:   alu_op = rv_ctrl_pkg::alu_xor;
                    {rv_ctrl_pkg::F7_BASE, 3'b101}:   alu_op = rv_ctrl_pkg::alu_srl;
                    {rv_ctrl_pkg::F7_ALT, 3'b101}:    alu_op = rv_ctrl_pkg::alu_sra;
                    {rv_ctrl_pkg::F7_BASE, 3'b110}:   alu_op = rv_ctrl_pkg::alu_or;
                    {rv_ctrl_pkg::F7_BASE, 3'b111}:   alu_op = rv_ctrl_pkg::alu_and;
                    {rv_ctrl_pkg::F7_MULDIV, 3'b000}: alu_op = rv_ctrl_pkg::alu_mul;
                    {rv_ctrl_pkg::F7_MULDIV, 3'b101}: alu_op = rv_ctrl_pkg::alu_divu;
                    {rv_ctrl_pkg::F7_MULDIV, 3'b111}: alu_op = rv_ctrl_pkg::alu_remu;
                    default:                          illegal = 1'b1;
                endcase
            end
            rv_ctrl_pkg::OPC_OP_32: begin
                reg_wen = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                word_op = 1'b1;
                case ({funct7, funct3})
                    {rv_ctrl_pkg::F7_BASE, 3'b000}:   alu_op = rv_ctrl_pkg::alu_add;
                    {rv_ctrl_pkg::F7_ALT, 3'b000}:    alu_op = rv_ctrl_pkg::alu_sub;
                    {rv_ctrl_pkg::F7_BASE, 3'b001}:   alu_op = rv_ctrl_pkg::alu_sll;
                    {rv_ctrl_pkg::F7_BASE, 3'b101}:   alu_op = rv_ctrl_pkg::alu_srl;
                    {rv_ctrl_pkg::F7_ALT, 3'b101}:    alu_op = rv_ctrl_pkg::alu_sra;
                    {rv_ctrl_pkg::F7_MULDIV, 3'b000}: alu_op = rv_ctrl_pkg::alu_mul;
                    {rv_ctrl_pkg::F7_MULDIV, 3'b100}: alu_op = rv_ctrl_pkg::alu_divw;
                    {rv_ctrl_pkg::F7_MULDIV, 3'b110}: alu_op = rv_ctrl_pkg::alu_remw;
                    default:                          illegal = 1'b1;
                endcase
            end
            rv_ctrl_pkg::OPC_OP_IMM, rv_ctrl_pkg::OPC_OP_IMM_32: begin
                word_op  = (opcode == rv_ctrl_pkg::OPC_OP_IMM_32);
                reg_wen  = 1'b1;
                use_rs1  = 1'b1;
                alu_src  = rv_ctrl_pkg::src_imm;
                imm_kind = rv_ctrl_pkg::imm_i;
                case (funct3)
                    3'b000:  alu_op = rv_ctrl_pkg::alu_add;
                    3'b001:  alu_op = rv_ctrl_pkg::alu_sll;
                    3'b010:  alu_op = rv_ctrl_pkg::alu_slt;
                    3'b011:  alu_op = rv_ctrl_pkg::alu_sltu;
                    3'b100:  alu_op = rv_ctrl_pkg::alu_xor;
                    3'b110:  alu_op = rv_ctrl_pkg::alu_or;
                    3'b111:  alu_op = rv_ctrl_pkg::alu_and;
                    default: alu_op = shift_f7[5] ? rv_ctrl_pkg::alu_sra : rv_ctrl_pkg::alu_srl;
                endcase
                if (funct3[1:0] == 2'b01) begin  // shifts
                    imm_kind = rv_ctrl_pkg::imm_shamt;
                    illegal  = (shift_f7 != rv_ctrl_pkg::F7_BASE) &&
                               (shift_f7 != rv_ctrl_pkg::F7_ALT || !funct3[2]);
                end else if (word_op && funct3 != 3'b000) begin
                    illegal = 1'b1;  // only addiw among the rest
                end
            end
            rv_ctrl_pkg::OPC_LOAD: begin
                reg_wen      = 1'b1;
                use_rs1      = 1'b1;
                mem_read     = 1'b1;
                mem_size     = funct3[1:0];
                mem_unsigned = funct3[2];
                alu_op       = rv_ctrl_pkg::alu_add;
                alu_src      = rv_ctrl_pkg::src_imm;
                imm_kind     = rv_ctrl_pkg::imm_i;
                illegal      = (funct3 == 3'b111);
            end
            rv_ctrl_pkg::OPC_STORE: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                mem_write = 1'b1;
                mem_size  = funct3[1:0];
                alu_op    = rv_ctrl_pkg::alu_add;
                alu_src   = rv_ctrl_pkg::src_imm;
                imm_kind  = rv_ctrl_pkg::imm_s;
                illegal   = funct3[2];
            end
            rv_ctrl_pkg::OPC_BRANCH: begin
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                branch   = 1'b1;
                imm_kind = rv_ctrl_pkg::imm_b;
                case (funct3)
                    3'b000:  alu_op = rv_ctrl_pkg::alu_beq_cmp;
                    3'b001:  alu_op = rv_ctrl_pkg::alu_bne_cmp;
                    3'b100:  alu_op = rv_ctrl_pkg::alu_blt_cmp;
                    3'b101:  alu_op = rv_ctrl_pkg::alu_bge_cmp;
                    3'b110:  alu_op = rv_ctrl_pkg::alu_bltu_cmp;
                    3'b111:  alu_op = rv_ctrl_pkg::alu_bgeu_cmp;
                    default: illegal = 1'b1;
                endcase
            end
            rv_ctrl_pkg::OPC_JAL, rv_ctrl_pkg::OPC_JALR: begin
                jalr     = (opcode == rv_ctrl_pkg::OPC_JALR);
                reg_wen  = 1'b1;
                use_rs1  = jalr;
                jump     = 1'b1;
                alu_op   = rv_ctrl_pkg::alu_add;
                alu_src  = rv_ctrl_pkg::src_pc_plus4;  // link value
                imm_kind = jalr ? rv_ctrl_pkg::imm_i : rv_ctrl_pkg::imm_j;
                illegal  = jalr && funct3 != 3'b000;
            end
            rv_ctrl_pkg::OPC_LUI, rv_ctrl_pkg::OPC_AUIPC: begin
                reg_wen  = 1'b1;
                alu_op   = rv_ctrl_pkg::alu_add;
                alu_src  = (opcode == rv_ctrl_pkg::OPC_LUI) ? rv_ctrl_pkg::src_imm
                                                            : rv_ctrl_pkg::src_imm_plus_pc;
                imm_kind = rv_ctrl_pkg::imm_u;
            end
            rv_ctrl_pkg::OPC_SYSTEM: begin
                ebreak  = (inst == rv_ctrl_pkg::EBREAK_INST);
                illegal = !ebreak;  // ecall, csr ops not kept
            end
            default: illegal = 1'b1;
        endcase
    end

    always_comb begin
        ctrl = '0;
        if (illegal) begin
            ctrl[rv_ctrl_pkg::OFS_ILLEGAL] = 1'b1;
        end else begin
            ctrl[rv_ctrl_pkg::OFS_EBREAK]       = ebreak;
            ctrl[rv_ctrl_pkg::OFS_REG_WEN]      = reg_wen;
            ctrl[rv_ctrl_pkg::OFS_RD +: 5]      = reg_wen ? inst[11:7] : 5'd0;
            ctrl[rv_ctrl_pkg::OFS_RS1 +: 5]     = use_rs1 ? inst[19:15] : 5'd0;
            ctrl[rv_ctrl_pkg::OFS_RS2 +: 5]     = use_rs2 ? inst[24:20] : 5'd0;
            ctrl[rv_ctrl_pkg::OFS_ALU_OP +: 5]  = alu_op;
            ctrl[rv_ctrl_pkg::OFS_ALU_SRC +: 2] = alu_src;
            ctrl[rv_ctrl_pkg::OFS_IMM_KIND +: 3] = imm_kind;
            ctrl[rv_ctrl_pkg::OFS_BRANCH]       = branch;
            ctrl[rv_ctrl_pkg::OFS_JUMP]         = jump;
            ctrl[rv_ctrl_pkg::OFS_JALR]         = jalr;
            ctrl[rv_ctrl_pkg::OFS_MEM_READ]     = mem_read;
            ctrl[rv_ctrl_pkg::OFS_MEM_WRITE]    = mem_write;
            ctrl[rv_ctrl_pkg::OFS_MEM_SIZE +: 2] = mem_size;
            ctrl[rv_ctrl_pkg::OFS_MEM_UNSIGNED] = mem_unsigned;
            ctrl[rv_ctrl_pkg::OFS_WORD_OP]      = word_op;
        end
    end

endmodule

/* rtl/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

    localparam int REG_W      = 5;
    localparam int ALU_OP_W   = 5;
    localparam int ALU_SRC_W  = 2;
    localparam int IMM_KIND_W = 3;
    localparam int MEM_SIZE_W = 2;

    typedef logic [31:0]           inst_t;
    typedef logic [REG_W-1:0]      reg_addr_t;
    typedef logic [MEM_SIZE_W-1:0] mem_size_t;  // byte, half, word, double

    typedef enum logic [ALU_OP_W-1:0] {
        alu_add = 5'd1, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra,
        alu_mul, alu_divu, alu_remu, alu_divw, alu_remw,
        alu_beq_cmp, alu_bne_cmp, alu_blt_cmp, alu_bge_cmp, alu_bltu_cmp, alu_bgeu_cmp,
        alu_none = 5'd0
    } alu_op_e;

    typedef enum logic [ALU_SRC_W-1:0] {
        src_reg, src_imm, src_pc_plus4, src_imm_plus_pc
    } alu_src_e;

    typedef enum logic [IMM_KIND_W-1:0] {
        imm_none, imm_i, imm_s, imm_b, imm_u, imm_j, imm_shamt
    } imm_kind_e;

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;  // sub, sra
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    localparam inst_t EBREAK_INST = 32'h0010_0073;
    localparam int    FIFO_DEPTH  = 4;

    localparam int OFS_WORD_OP      = 0;
    localparam int OFS_MEM_UNSIGNED = 1;
    localparam int OFS_MEM_SIZE     = 2;
    localparam int OFS_MEM_WRITE    = 4;
    localparam int OFS_MEM_READ     = 5;
    localparam int OFS_JALR         = 6;
    localparam int OFS_JUMP         = 7;
    localparam int OFS_BRANCH       = 8;
    localparam int OFS_IMM_KIND     = 9;
    localparam int OFS_ALU_SRC      = 12;
    localparam int OFS_ALU_OP       = 14;
    localparam int OFS_RS2          = 19;
    localparam int OFS_RS1          = 24;
    localparam int OFS_RD           = 29;
    localparam int OFS_REG_WEN      = 34;
    localparam int OFS_EBREAK       = 35;
    localparam int OFS_ILLEGAL      = 36;
    localparam int CTRL_W           = 37;

    typedef logic [CTRL_W-1:0] ctrl_word_t;

endpackage
